//--- design/mipsPkg.sv
/* MIPS core shared definitions */
package mipsPkg;

	// Word size of registers, ALU and instructions
	localparam int dataWidth = 32;
	// Register index width, 32 registers
	localparam int regAddrWidth = 5;

	// Instruction memory size in words
	localparam int memoryDepth = 512;
	// Word address bits for the instruction memory
	localparam int pcWidth = $clog2(memoryDepth);

	// Primary opcodes, instr[31:26]
	localparam logic [5:0] opRType = 6'h00;
	localparam logic [5:0] opBeq = 6'h04;
	localparam logic [5:0] opBne = 6'h05;
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] opOri = 6'h0d;

	// R-type funct field, instr[5:0]
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnNor = 6'h27;

	// Register word and register index
	typedef logic [dataWidth-1:0] regT;
	typedef logic [regAddrWidth-1:0] regAddrT;

	// ALU operation selected in decode
	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr = 3'd3,
		aluNor = 3'd4
	} aluOpE;

endpackage

//--- design/aluUnit.sv
/* Integer ALU */
module aluUnit (
	input  mipsPkg::aluOpE aluOp,
	input  mipsPkg::regT opA,
	input  mipsPkg::regT opB,
	output mipsPkg::regT result
);

	// Single cycle, no flags
	// overflow on add and sub wraps
	always_comb begin
		case (aluOp)
			mipsPkg::aluAdd: begin
				result = opA + opB;
			end
			mipsPkg::aluSub: begin
				result = opA - opB;
			end
			mipsPkg::aluAnd: begin
				result = opA & opB;
			end
			// Also ori with the zero extended immediate
			mipsPkg::aluOr: begin
				result = opA | opB;
			end
			mipsPkg::aluNor: begin
				result = ~(opA | opB);
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

//--- design/branchUnit.sv
/* Branch resolution */
module branchUnit (
	input  logic isBeq,
	input  logic isBne,
	input  mipsPkg::regT opA,
	input  mipsPkg::regT opB,
	input  mipsPkg::regT pcPlus4,
	input  mipsPkg::regT imm,
	output logic taken,
	output mipsPkg::regT target
);

	logic equal;

	// Operands arrive already forwarded
	assign equal = (opA == opB);

	// beq on equal, bne on not equal
	assign taken = (isBeq && equal) || (isBne && !equal);

	// Word offset relative to the next instruction
	assign target = pcPlus4 + {imm[mipsPkg::dataWidth-3:0], 2'b00};

endmodule

//--- design/fetchStage.sv
/* Fetch stage */
module fetchStage (
	input  logic clk,
	input  logic arstN,
	input  logic run,
	input  logic imemWe,
	input  logic [mipsPkg::pcWidth-1:0] imemAddr,
	input  mipsPkg::regT imemData,
	input  logic redirect,
	input  mipsPkg::regT redirectPc,
	output mipsPkg::regT instr,
	output mipsPkg::regT pcPlus4,
	output logic fetchValid
);

	// Program storage, word addressed
	mipsPkg::regT imem [mipsPkg::memoryDepth];

	// Byte address of the next sequential fetch
	mipsPkg::regT pcReg;
	mipsPkg::regT fetchPc;
	mipsPkg::regT nextPc;
	logic [mipsPkg::pcWidth-1:0] wordIdx;

	// Branch target fetched in the redirect cycle itself
	// so the wrong path after the branch costs only two slots
	assign fetchPc = redirect ? redirectPc : pcReg;
	assign nextPc = fetchPc + mipsPkg::regT'(4);
	// Drop byte offset bits
	assign wordIdx = fetchPc[mipsPkg::pcWidth+1:2];

	// Load port, used while the core is held
	always_ff @(posedge clk) begin
		if (imemWe) begin
			imem[imemAddr] <= imemData;
		end
	end

	// PC and fetch valid
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pcReg <= '0;
			fetchValid <= 1'b0;
		end else if (!run) begin
			// Held core restarts from word 0
			pcReg <= '0;
			fetchValid <= 1'b0;
		end else begin
			pcReg <= nextPc;
			fetchValid <= 1'b1;
		end
	end

	// Fetch to decode register
	always_ff @(posedge clk) begin
		instr <= imem[wordIdx];
		pcPlus4 <= nextPc;
	end

	// Program load only while held
	aLoadWhileHeld: assert property (
		@(posedge clk) disable iff (!arstN) imemWe |-> !run
	);

endmodule

//--- design/decodeStage.sv
/* Decode stage and register file */
module decodeStage (
	input  logic clk,
	input  logic arstN,
	input  logic run,
	input  logic flush,
	input  mipsPkg::regT instr,
	input  mipsPkg::regT pcPlus4In,
	input  logic fetchValid,
	input  logic wbValid,
	input  mipsPkg::regAddrT wbAddr,
	input  mipsPkg::regT wbData,
	output mipsPkg::regT rsData,
	output mipsPkg::regT rtData,
	output mipsPkg::regT imm,
	output mipsPkg::regAddrT rsAddr,
	output mipsPkg::regAddrT rtAddr,
	output mipsPkg::regAddrT destAddr,
	output mipsPkg::aluOpE aluOp,
	output logic aluSrc,
	output logic regWrite,
	output logic isBeq,
	output logic isBne,
	output mipsPkg::regT pcPlus4,
	output logic decValid
);

	localparam int numRegs = 2 ** mipsPkg::regAddrWidth;

	// Instruction fields
	logic [5:0] opcode;
	logic [5:0] funct;
	mipsPkg::regAddrT rs;
	mipsPkg::regAddrT rt;
	mipsPkg::regAddrT rd;

	mipsPkg::regT regs [numRegs];
	mipsPkg::regT rsRead;
	mipsPkg::regT rtRead;

	// Decoded controls
	mipsPkg::regT immExt;
	mipsPkg::aluOpE ctlAluOp;
	logic ctlAluSrc;
	logic ctlRegWrite;
	logic ctlBeq;
	logic ctlBne;
	logic ctlDestRt;
	mipsPkg::regAddrT ctlDest;

	assign opcode = instr[31:26];
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign funct = instr[5:0];

	// Control decoder
	// unknown words fall through with no write and no branch
	always_comb begin
		ctlAluOp = mipsPkg::aluAdd;
		ctlAluSrc = 1'b0;
		ctlRegWrite = 1'b0;
		ctlBeq = 1'b0;
		ctlBne = 1'b0;
		ctlDestRt = 1'b0;
		// Sign extension unless ori
		immExt = {{(mipsPkg::dataWidth-16){instr[15]}}, instr[15:0]};
		case (opcode)
			mipsPkg::opRType: begin
				ctlRegWrite = 1'b1;
				case (funct)
					mipsPkg::fnAdd: ctlAluOp = mipsPkg::aluAdd;
					mipsPkg::fnSub: ctlAluOp = mipsPkg::aluSub;
					mipsPkg::fnAnd: ctlAluOp = mipsPkg::aluAnd;
					mipsPkg::fnOr: ctlAluOp = mipsPkg::aluOr;
					mipsPkg::fnNor: ctlAluOp = mipsPkg::aluNor;
					default: ctlRegWrite = 1'b0;
				endcase
			end
			mipsPkg::opAddi: begin
				ctlAluSrc = 1'b1;
				ctlRegWrite = 1'b1;
				ctlDestRt = 1'b1;
			end
			mipsPkg::opOri: begin
				ctlAluOp = mipsPkg::aluOr;
				ctlAluSrc = 1'b1;
				ctlRegWrite = 1'b1;
				ctlDestRt = 1'b1;
				// Logical immediate, zero extended
				immExt = {{(mipsPkg::dataWidth-16){1'b0}}, instr[15:0]};
			end
			mipsPkg::opBeq: ctlBeq = 1'b1;
			mipsPkg::opBne: ctlBne = 1'b1;
			default: ctlRegWrite = 1'b0;
		endcase
	end

	assign ctlDest = ctlDestRt ? rt : rd;

	// Register file, written from the writeback register
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (wbValid) begin
			regs[wbAddr] <= wbData;
		end
	end

	// Write-through read ports
	assign rsRead = (wbValid && wbAddr == rs) ? wbData : regs[rs];
	assign rtRead = (wbValid && wbAddr == rt) ? wbData : regs[rt];

	// Decode to execute valid
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			decValid <= 1'b0;
		end else if (!run || flush) begin
			decValid <= 1'b0;
		end else begin
			decValid <= fetchValid;
		end
	end

	// Decode to execute payload
	always_ff @(posedge clk) begin
		rsData <= rsRead;
		rtData <= rtRead;
		imm <= immExt;
		rsAddr <= rs;
		rtAddr <= rt;
		destAddr <= ctlDest;
		aluOp <= ctlAluOp;
		aluSrc <= ctlAluSrc;
		// r0 destination turns into a no-op
		regWrite <= ctlRegWrite && (ctlDest != '0);
		isBeq <= ctlBeq;
		isBne <= ctlBne;
		pcPlus4 <= pcPlus4In;
	end

	// r0 stays zero across decode, execute and writeback
	aNoR0Write: assert property (
		@(posedge clk) disable iff (!arstN) wbValid |-> wbAddr != '0
	);

endmodule

//--- design/executeStage.sv
/* Execute stage with writeback register */
module executeStage (
	input  logic clk,
	input  logic arstN,
	input  logic run,
	input  logic decValid,
	input  mipsPkg::regT rsData,
	input  mipsPkg::regT rtData,
	input  mipsPkg::regAddrT rsAddr,
	input  mipsPkg::regAddrT rtAddr,
	input  mipsPkg::regT imm,
	input  mipsPkg::regAddrT destAddr,
	input  mipsPkg::aluOpE aluOp,
	input  logic aluSrc,
	input  logic regWrite,
	input  logic isBeq,
	input  logic isBne,
	input  mipsPkg::regT pcPlus4,
	output logic wbValid,
	output mipsPkg::regAddrT wbAddr,
	output mipsPkg::regT wbData,
	output logic redirect,
	output mipsPkg::regT redirectPc,
	output mipsPkg::regT aluResult
);

	mipsPkg::regT fwdA;
	mipsPkg::regT fwdB;
	mipsPkg::regT aluB;
	mipsPkg::regT aluOut;
	mipsPkg::regT brTarget;
	logic brTaken;
	logic live;

	// Result of the previous instruction still in the writeback register
	assign fwdA = (wbValid && wbAddr == rsAddr) ? wbData : rsData;
	assign fwdB = (wbValid && wbAddr == rtAddr) ? wbData : rtData;
	// Immediate for addi and ori
	assign aluB = aluSrc ? imm : fwdB;

	aluUnit i_aluUnit (
		.aluOp(aluOp),
		.opA(fwdA),
		.opB(aluB),
		.result(aluOut)
	);

	branchUnit i_branchUnit (
		.isBeq(isBeq),
		.isBne(isBne),
		.opA(fwdA),
		.opB(fwdB),
		.pcPlus4(pcPlus4),
		.imm(imm),
		.taken(brTaken),
		.target(brTarget)
	);

	// Instruction right behind a taken branch is squashed here
	assign live = decValid && !redirect;

	// Writeback and redirect valids
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wbValid <= 1'b0;
			redirect <= 1'b0;
			aluResult <= '0;
		end else if (!run) begin
			wbValid <= 1'b0;
			redirect <= 1'b0;
		end else begin
			wbValid <= live && regWrite;
			redirect <= live && brTaken;
			// Holds the last executed result across bubbles
			if (live) begin
				aluResult <= aluOut;
			end
		end
	end

	// Writeback and redirect payload
	always_ff @(posedge clk) begin
		wbAddr <= destAddr;
		wbData <= aluOut;
		redirectPc <= brTarget;
	end

	// Branches never write a register
	aBranchNoWrite: assert property (
		@(posedge clk) disable iff (!arstN) redirect |-> !wbValid
	);

endmodule

//--- design/mipsCore.sv
/* Pipelined MIPS core */
module mipsCore (
	input  logic clk,
	input  logic arstN,
	input  logic run,
	input  logic imemWe,
	input  logic [mipsPkg::pcWidth-1:0] imemAddr,
	input  mipsPkg::regT imemData,
	output logic wbValid,
	output mipsPkg::regAddrT wbAddr,
	output mipsPkg::regT wbData,
	output mipsPkg::regT aluResult
);

	// Fetch to decode
	mipsPkg::regT fetchInstr;
	mipsPkg::regT fetchPcPlus4;
	logic fetchValid;

	// Decode to execute
	mipsPkg::regT decRsData;
	mipsPkg::regT decRtData;
	mipsPkg::regT decImm;
	mipsPkg::regAddrT decRsAddr;
	mipsPkg::regAddrT decRtAddr;
	mipsPkg::regAddrT decDestAddr;
	mipsPkg::aluOpE decAluOp;
	logic decAluSrc;
	logic decRegWrite;
	logic decIsBeq;
	logic decIsBne;
	mipsPkg::regT decPcPlus4;
	logic decValid;

	// Execute back to fetch and decode
	logic redirect;
	mipsPkg::regT redirectPc;

	fetchStage i_fetchStage (
		.clk(clk),
		.arstN(arstN),
		.run(run),
		.imemWe(imemWe),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.instr(fetchInstr),
		.pcPlus4(fetchPcPlus4),
		.fetchValid(fetchValid)
	);

	// Writeback port closes the loop into the register file
	decodeStage i_decodeStage (
		.clk(clk),
		.arstN(arstN),
		.run(run),
		.flush(redirect),
		.instr(fetchInstr),
		.pcPlus4In(fetchPcPlus4),
		.fetchValid(fetchValid),
		.wbValid(wbValid),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.rsData(decRsData),
		.rtData(decRtData),
		.imm(decImm),
		.rsAddr(decRsAddr),
		.rtAddr(decRtAddr),
		.destAddr(decDestAddr),
		.aluOp(decAluOp),
		.aluSrc(decAluSrc),
		.regWrite(decRegWrite),
		.isBeq(decIsBeq),
		.isBne(decIsBne),
		.pcPlus4(decPcPlus4),
		.decValid(decValid)
	);

	executeStage i_executeStage (
		.clk(clk),
		.arstN(arstN),
		.run(run),
		.decValid(decValid),
		.rsData(decRsData),
		.rtData(decRtData),
		.rsAddr(decRsAddr),
		.rtAddr(decRtAddr),
		.imm(decImm),
		.destAddr(decDestAddr),
		.aluOp(decAluOp),
		.aluSrc(decAluSrc),
		.regWrite(decRegWrite),
		.isBeq(decIsBeq),
		.isBne(decIsBne),
		.pcPlus4(decPcPlus4),
		.wbValid(wbValid),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.aluResult(aluResult)
	);

endmodule

//--- include/mipsInstrEnc.svh
/* Instruction word encoders */
`ifndef MIPS_INSTR_ENC_SVH
`define MIPS_INSTR_ENC_SVH

// R-type word, shamt always zero
function automatic mipsPkg::regT encR(
	input logic [5:0] funct,
	input mipsPkg::regAddrT rd,
	input mipsPkg::regAddrT rs,
	input mipsPkg::regAddrT rt
);
	return {mipsPkg::opRType, rs, rt, rd, 5'd0, funct};
endfunction

// I-type word, rt is the destination for addi and ori
function automatic mipsPkg::regT encI(
	input logic [5:0] opcode,
	input mipsPkg::regAddrT rt,
	input mipsPkg::regAddrT rs,
	input logic [15:0] imm16
);
	return {opcode, rs, rt, imm16};
endfunction

// Conditional branch
// offset counts words from the branch's pcPlus4
function automatic mipsPkg::regT encBranch(
	input logic notEqual,
	input mipsPkg::regAddrT rs,
	input mipsPkg::regAddrT rt,
	input logic [15:0] offset
);
	logic [5:0] opcode;
	opcode = notEqual ? mipsPkg::opBne : mipsPkg::opBeq;
	return {opcode, rs, rt, offset};
endfunction

`endif

//--- dv/mipsCoreTb.sv
/* MIPS core testbench */
module mipsCoreTb;

	// Longest program of any test, in words
	localparam int maxProgLen = 24;
	localparam int numTests = 6;
	// Full memory load, run window and drain for one test
	localparam int perTestCycles = mipsPkg::memoryDepth + 2 * maxProgLen + 40;
	localparam int cycleLimit = 20 + numTests * perTestCycles;

	logic clk;
	logic arstN;
	logic run;
	logic imemWe;
	logic [mipsPkg::pcWidth-1:0] imemAddr;
	mipsPkg::regT imemData;
	logic wbValid;
	mipsPkg::regAddrT wbAddr;
	mipsPkg::regT wbData;
	mipsPkg::regT aluResult;

	integer seed;
	int errorCount;
	int checkCount;
	int cycleCount;

	// Program under test and expected writebacks
	mipsPkg::regT progWords [$];
	mipsPkg::regAddrT expAddr [$];
	mipsPkg::regT expData [$];
	// Reference register file, kept across tests like the DUT's
	mipsPkg::regT modelRegs [32];

	`include "mipsInstrEnc.svh"

	mipsCore i_mipsCore (
		.clk(clk),
		.arstN(arstN),
		.run(run),
		.imemWe(imemWe),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.wbValid(wbValid),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.aluResult(aluResult)
	);

	always #5 clk = ~clk;

	// Global run limit
	initial begin
		cycleCount = 0;
		while (cycleCount < cycleLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout after %0d cycles, the tests did not complete", cycleCount);
		$display("Finished with errors");
		$finish;
	end

	task automatic checkReg(input string name, input mipsPkg::regT got,
			input mipsPkg::regT exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkAddr(input string name, input mipsPkg::regAddrT got,
			input mipsPkg::regAddrT exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic noteFailure(input string msg);
		errorCount++;
		$display("Error at %0t: %s", $time, msg);
	endtask

	// Random register 1 to 31
	function automatic mipsPkg::regAddrT randReg();
		int r;
		r = $random(seed);
		return mipsPkg::regAddrT'(1 + ((r & 32'h7fff_ffff) % 31));
	endfunction

	function automatic logic [15:0] randImm();
		int r;
		r = $random(seed);
		return r[15:0];
	endfunction

	// Whole memory written, zeros past the program
	task automatic loadProgram();
		logic [mipsPkg::pcWidth-1:0] addr;
		for (int i = 0; i < mipsPkg::memoryDepth; i++) begin
			addr = i[mipsPkg::pcWidth-1:0];
			@(posedge clk);
			imemWe <= 1'b1;
			imemAddr <= addr;
			imemData <= (i < progWords.size()) ? progWords[i] : '0;
		end
		@(posedge clk);
		imemWe <= 1'b0;
	endtask

	// Instruction-level model, word addressed PC
	task automatic modelRun();
		int pc;
		int steps;
		mipsPkg::regT w;
		mipsPkg::regT a;
		mipsPkg::regT b;
		mipsPkg::regT sext;
		mipsPkg::regT res;
		mipsPkg::regAddrT dest;
		logic write;
		expAddr.delete();
		expData.delete();
		pc = 0;
		steps = 0;
		// Past the program only zero words remain
		while (pc < progWords.size() && steps < mipsPkg::memoryDepth) begin
			w = progWords[pc];
			a = modelRegs[w[25:21]];
			b = modelRegs[w[20:16]];
			sext = {{(mipsPkg::dataWidth-16){w[15]}}, w[15:0]};
			dest = w[15:11];
			res = '0;
			write = 1'b0;
			pc++;
			steps++;
			case (w[31:26])
				mipsPkg::opRType: begin
					write = 1'b1;
					case (w[5:0])
						mipsPkg::fnAdd: res = a + b;
						mipsPkg::fnSub: res = a - b;
						mipsPkg::fnAnd: res = a & b;
						mipsPkg::fnOr: res = a | b;
						mipsPkg::fnNor: res = ~(a | b);
						default: write = 1'b0;
					endcase
				end
				mipsPkg::opAddi: begin
					write = 1'b1;
					dest = w[20:16];
					res = a + sext;
				end
				mipsPkg::opOri: begin
					write = 1'b1;
					dest = w[20:16];
					res = a | {{(mipsPkg::dataWidth-16){1'b0}}, w[15:0]};
				end
				// Offset counts words past the branch
				mipsPkg::opBeq: begin
					if (a == b) begin
						pc = pc + $signed(w[15:0]);
					end
				end
				mipsPkg::opBne: begin
					if (a != b) begin
						pc = pc + $signed(w[15:0]);
					end
				end
				default: begin
					write = 1'b0;
				end
			endcase
			// r0 is never written
			if (write && dest != '0) begin
				modelRegs[dest] = res;
				expAddr.push_back(dest);
				expData.push_back(res);
			end
		end
	endtask

	// Load, run, compare writebacks in order, then hold the core again
	task automatic runProgram(input string name);
		int seen;
		int cycles;
		int limit;
		loadProgram();
		modelRun();
		seen = 0;
		cycles = 0;
		limit = progWords.size() + 20;
		@(posedge clk);
		run <= 1'b1;
		while (seen < expAddr.size() && cycles < limit) begin
			@(negedge clk);
			cycles++;
			if (wbValid === 1'b1) begin
				checkAddr("wbAddr", wbAddr, expAddr[seen]);
				checkReg("wbData", wbData, expData[seen]);
				// Loaded on the same edge as the writeback
				checkReg("aluResult", aluResult, expData[seen]);
				seen++;
			end
		end
		if (seen < expAddr.size()) begin
			noteFailure($sformatf("%s saw only %0d of %0d writebacks",
				name, seen, expAddr.size()));
		end
		// Trailing zero words must stay silent
		repeat (4) begin
			@(negedge clk);
			if (wbValid === 1'b1) begin
				noteFailure($sformatf("%s has an extra writeback to r%0d", name, wbAddr));
			end
		end
		@(posedge clk);
		run <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	task automatic idleThenFirstWrite();
		// Held core stays quiet
		repeat (8) begin
			@(negedge clk);
			if (wbValid !== 1'b0) begin
				noteFailure("wbValid is not low while run is low");
			end
		end
		progWords.delete();
		progWords.push_back(encI(mipsPkg::opAddi, 5'd1, 5'd0, randImm()));
		progWords.push_back(encI(mipsPkg::opAddi, 5'd2, 5'd1, randImm()));
		runProgram("first write");
	endtask

	task automatic rTypeOps();
		mipsPkg::regAddrT src [4];
		logic [5:0] fn [5];
		progWords.delete();
		fn = '{mipsPkg::fnAdd, mipsPkg::fnSub, mipsPkg::fnAnd, mipsPkg::fnOr,
			mipsPkg::fnNor};
		// Random sources first
		for (int i = 0; i < 4; i++) begin
			src[i] = randReg();
			progWords.push_back(encI(mipsPkg::opAddi, src[i], 5'd0, randImm()));
		end
		for (int i = 0; i < 5; i++) begin
			progWords.push_back(encR(fn[i], randReg(), src[i % 4], src[(i + 1) % 4]));
		end
		runProgram("R-type ops");
	endtask

	task automatic immediateExtension();
		mipsPkg::regAddrT rA;
		mipsPkg::regAddrT rB;
		mipsPkg::regAddrT rC;
		logic [15:0] negA;
		logic [15:0] negB;
		progWords.delete();
		rA = randReg();
		rB = randReg();
		rC = randReg();
		// Sign bit forced on
		negA = randImm() | 16'h8000;
		negB = randImm() | 16'h8000;
		progWords.push_back(encI(mipsPkg::opAddi, rA, 5'd0, negA));
		progWords.push_back(encI(mipsPkg::opOri, rB, 5'd0, negB));
		progWords.push_back(encI(mipsPkg::opOri, rC, rA, negB));
		progWords.push_back(encI(mipsPkg::opAddi, rC, rB, negA));
		runProgram("immediates");
	endtask

	task automatic dependentChain();
		progWords.delete();
		progWords.push_back(encI(mipsPkg::opAddi, 5'd10, 5'd0, randImm()));
		// Distance one, from the writeback register
		progWords.push_back(encI(mipsPkg::opAddi, 5'd10, 5'd10, randImm()));
		progWords.push_back(encR(mipsPkg::fnAdd, 5'd11, 5'd10, 5'd10));
		// Distance two through the write-through read
		progWords.push_back(encR(mipsPkg::fnSub, 5'd12, 5'd11, 5'd10));
		progWords.push_back(encR(mipsPkg::fnOr, 5'd13, 5'd10, 5'd12));
		progWords.push_back(encR(mipsPkg::fnNor, 5'd14, 5'd13, 5'd11));
		progWords.push_back(encR(mipsPkg::fnAnd, 5'd15, 5'd14, 5'd13));
		progWords.push_back(encI(mipsPkg::opAddi, 5'd15, 5'd15, randImm()));
		runProgram("forwarding");
	endtask

	task automatic branchSkips();
		logic [15:0] immA;
		progWords.delete();
		immA = randImm();
		// r1 equals r2, r3 differs
		progWords.push_back(encI(mipsPkg::opAddi, 5'd1, 5'd0, immA));
		progWords.push_back(encI(mipsPkg::opAddi, 5'd2, 5'd0, immA));
		progWords.push_back(encI(mipsPkg::opAddi, 5'd3, 5'd0, immA ^ 16'h0001));
		// Taken beq skips two
		progWords.push_back(encBranch(1'b0, 5'd1, 5'd2, 16'd2));
		progWords.push_back(encI(mipsPkg::opAddi, 5'd4, 5'd0, 16'd1));
		progWords.push_back(encI(mipsPkg::opAddi, 5'd4, 5'd0, 16'd2));
		// Taken bne right after a redirect
		progWords.push_back(encBranch(1'b1, 5'd1, 5'd3, 16'd2));
		progWords.push_back(encI(mipsPkg::opAddi, 5'd5, 5'd0, 16'd3));
		progWords.push_back(encI(mipsPkg::opAddi, 5'd5, 5'd0, 16'd4));
		// Not taken pair
		progWords.push_back(encBranch(1'b0, 5'd1, 5'd3, 16'd1));
		progWords.push_back(encI(mipsPkg::opAddi, 5'd6, 5'd0, 16'd5));
		progWords.push_back(encBranch(1'b1, 5'd1, 5'd2, 16'd1));
		progWords.push_back(encI(mipsPkg::opAddi, 5'd7, 5'd0, 16'd6));
		// Branch operand forwarded from the previous instruction
		progWords.push_back(encI(mipsPkg::opAddi, 5'd9, 5'd0, immA));
		progWords.push_back(encBranch(1'b0, 5'd9, 5'd1, 16'd2));
		progWords.push_back(encI(mipsPkg::opAddi, 5'd8, 5'd0, 16'd7));
		progWords.push_back(encI(mipsPkg::opAddi, 5'd8, 5'd0, 16'd8));
		progWords.push_back(encI(mipsPkg::opAddi, 5'd10, 5'd9, 16'd9));
		runProgram("branches");
	endtask

	task automatic regZeroAndNoops();
		mipsPkg::regAddrT rA;
		progWords.delete();
		rA = randReg();
		progWords.push_back(encI(mipsPkg::opAddi, 5'd0, 5'd0, randImm()));
		progWords.push_back('0);
		progWords.push_back(encR(mipsPkg::fnAdd, 5'd0, rA, rA));
		progWords.push_back(encI(mipsPkg::opOri, 5'd0, 5'd0, 16'hffff));
		// Unknown funct, then a load opcode the core lacks
		progWords.push_back(encR(6'h3f, 5'd20, 5'd1, 5'd2));
		progWords.push_back({6'h23, 5'd1, 5'd2, 16'h0004});
		// r0 must still read as zero
		progWords.push_back(encR(mipsPkg::fnOr, 5'd21, 5'd0, 5'd0));
		progWords.push_back(encI(mipsPkg::opAddi, 5'd22, 5'd0, randImm()));
		progWords.push_back(encR(mipsPkg::fnAdd, 5'd23, 5'd0, 5'd22));
		runProgram("r0 and no-ops");
	endtask

	initial begin
		clk = 1'b0;
		arstN = 1'b0;
		run = 1'b0;
		imemWe = 1'b0;
		imemAddr = '0;
		imemData = '0;
		seed = 32'h8b5a_ed8f;
		errorCount = 0;
		checkCount = 0;
		for (int i = 0; i < 32; i++) begin
			modelRegs[i] = '0;
		end
		repeat (2) @(posedge clk);
		arstN <= 1'b1;

		idleThenFirstWrite();
		rTypeOps();
		immediateExtension();
		dependentChain();
		branchSkips();
		regZeroAndNoops();

		$display("Summary: %0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- all.f
+incdir+include
design/mipsPkg.sv
design/aluUnit.sv
design/branchUnit.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/mipsCore.sv
dv/mipsCoreTb.sv

//--- Bender.yml
package:
  name: mips_core

sources:
  - include_dirs:
      - include
    files:
      - design/mipsPkg.sv
      - design/aluUnit.sv
      - design/branchUnit.sv
      - design/fetchStage.sv
      - design/decodeStage.sv
      - design/executeStage.sv
      - design/mipsCore.sv

  - target: test
    include_dirs:
      - include
    files:
      - dv/mipsCoreTb.sv
